//--- all.f
+incdir+.
radio_rx_pkg.sv
rx_sample_if.sv
cmos_rx_deframer.sv
sample_gate.sv
sample_fifo.sv
stream_arbiter.sv
rx_ctrl_regs.sv
dual_rx_top.sv
tb_dual_rx.sv

//--- Bender.yml
package:
  name: dual_rx_capture

sources:
  - include_dirs:
      - .
    files:
      - radio_rx_pkg.sv
      - rx_sample_if.sv
      - cmos_rx_deframer.sv
      - sample_gate.sv
      - sample_fifo.sv
      - stream_arbiter.sv
      - rx_ctrl_regs.sv
      - dual_rx_top.sv
      - target: simulation
        files:
          - tb_dual_rx.sv

//--- tb_dual_rx.sv
// testbench for the dual receive capture path with random pins, gate model and stream checker

`timescale 1ns/1ps
`default_nettype none

`include "radio_rx_settings.svh"

module tb_dual_rx;

  localparam int IDLE_CYC    = 60;
  localparam int A_CYC       = 80;
  localparam int BYP_CYC     = 80;
  localparam int GATE_CYC    = 120;
  localparam int GATE_ROUNDS = 3;
  localparam int HOLD_CYC    = 60;
  localparam int RAND_CYC    = 200;
  localparam int STIM_CYC    = IDLE_CYC + A_CYC + 2 * BYP_CYC + GATE_ROUNDS * GATE_CYC
                               + HOLD_CYC + RAND_CYC;
  localparam int CYCLE_LIMIT = 4 * STIM_CYC + 1000;

  logic        clk;
  logic        arst_n;
  logic        a_rx_frame_in;
  logic [11:0] a_rx_data_p0;
  logic [11:0] a_rx_data_p1;
  logic        b_rx_frame_in;
  logic [11:0] b_rx_data_p0;
  logic [11:0] b_rx_data_p1;
  logic        a_enable;
  logic        b_enable;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        m_axis_tvalid;
  logic        m_axis_tready;
  logic [31:0] m_axis_tdata;

  // register model and gate model state
  logic        en_a_m;
  logic        en_b_m;
  logic        byp_m;
  logic [12:0] thr_m;
  logic [3:0]  pad_m;
  int          pad_left_m [4];
  logic [31:0] exp_a_q [$];
  logic [31:0] exp_b_q [$];
  int          pushed [2];
  int          delivered [2];
  bit          skip_ok;
  int          ready_mode;
  int          cycle_count = 0;

  dual_rx_top dut0 (.*);

  always #2 clk = ~clk;

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////
  // pin and tready drivers, model and output monitor
  //////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    a_rx_frame_in <= 1'($urandom);
    a_rx_data_p0  <= 12'($urandom);
    a_rx_data_p1  <= 12'($urandom);
    b_rx_frame_in <= 1'($urandom);
    b_rx_data_p0  <= 12'($urandom);
    b_rx_data_p1  <= 12'($urandom);
    case (ready_mode)
      0:       m_axis_tready <= 1'b1;
      1:       m_axis_tready <= 1'b0;
      default: m_axis_tready <= 1'($urandom);
    endcase
  end

  // gate rule per channel and push of the expected word to its receiver queue
  task automatic gate_and_push(input int rx, input logic frame, input logic [11:0] p0,
                               input logic [11:0] p1);
    int tag;
    int ii;
    int qq;
    bit above;
    bit pass;
    tag = rx * 2 + (frame ? 0 : 1);
    ii = $signed(p0);
    qq = $signed(p1);
    if (ii < 0) ii = -ii;
    if (qq < 0) qq = -qq;
    above = (ii + qq) >= int'(thr_m);
    pass = byp_m || above || (pad_left_m[tag] != 0);
    if (above) pad_left_m[tag] = pad_m;
    else if (pad_left_m[tag] != 0) pad_left_m[tag]--;
    if (pass) begin
      pushed[rx]++;
      if (rx == 0) exp_a_q.push_back({6'b0, 2'(tag), p0, p1});
      else exp_b_q.push_back({6'b0, 2'(tag), p0, p1});
    end
  endtask

  // dropped samples are skipped only when drops are allowed
  task automatic match_word(input logic [31:0] w);
    if (w[25] == 1'b0) begin
      while (skip_ok && exp_a_q.size() > 0 && exp_a_q[0] != w) void'(exp_a_q.pop_front());
      if (exp_a_q.size() == 0) stop_with_error("receiver a word arrived with nothing expected");
      check_equal("rx_a stream word", exp_a_q.pop_front(), w);
    end else begin
      while (skip_ok && exp_b_q.size() > 0 && exp_b_q[0] != w) void'(exp_b_q.pop_front());
      if (exp_b_q.size() == 0) stop_with_error("receiver b word arrived with nothing expected");
      check_equal("rx_b stream word", exp_b_q.pop_front(), w);
    end
    delivered[w[25]]++;
  endtask

  always @(posedge clk) begin
    if (arst_n) begin
      if (m_axis_tvalid && m_axis_tready) match_word(m_axis_tdata);
      if (en_a_m) gate_and_push(0, a_rx_frame_in, a_rx_data_p0, a_rx_data_p1);
      if (en_b_m) gate_and_push(1, b_rx_frame_in, b_rx_data_p0, b_rx_data_p1);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////
  // axi4-lite access
  //////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    @(posedge clk);
    while (!awready) @(posedge clk);
    check_equal("wready with awready", 32'd1, {31'b0, wready});
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    // registers change on the accepting edge
    case (addr)
      `REG_CTRL: begin
        if (strb[0]) begin
          en_a_m <= data[0];
          en_b_m <= data[1];
          byp_m  <= data[2];
        end
      end
      `REG_THRESH: begin
        if (strb[0]) thr_m[7:0] <= data[7:0];
        if (strb[1]) thr_m[12:8] <= data[12:8];
      end
      `REG_PAD: if (strb[0]) pad_m <= data[3:0];
      default: ;
    endcase
    @(posedge clk);
    while (!bvalid) @(posedge clk);
    check_equal("write response", 32'b0, {30'b0, bresp});
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge clk);
    while (!arready) @(posedge clk);
    arvalid <= 1'b0;
    @(posedge clk);
    while (!rvalid) @(posedge clk);
    check_equal("read response", 32'b0, {30'b0, rresp});
    data = rdata;
  endtask

  // drop counters read zero before any traffic
  function automatic logic [31:0] expected_reg(input logic [7:0] addr);
    case (addr)
      `REG_CTRL:   return {29'b0, byp_m, en_b_m, en_a_m};
      `REG_THRESH: return {19'b0, thr_m};
      `REG_PAD:    return {28'b0, pad_m};
      default:     return 32'b0;
    endcase
  endfunction

  function automatic logic [7:0] pick_addr();
    case ($urandom_range(0, 6))
      0:       return `REG_CTRL;
      1:       return `REG_THRESH;
      2:       return `REG_PAD;
      3:       return `REG_DROP_A;
      4:       return 8'h14;
      5:       return 8'h3C;
      default: return 8'hFC;
    endcase
  endfunction

  task automatic test_registers();
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] rd;
    for (int k = 0; k <= 16; k += 4) begin
      axi_read(8'(k), rd);
      check_equal("register after reset", 32'b0, rd);
    end
    repeat (16) begin
      addr = pick_addr();
      data = $urandom;
      // radios stay off during register checks
      if (addr == `REG_CTRL) data[1:0] = 2'b00;
      axi_write(addr, data, 4'($urandom));
      axi_read(addr, rd);
      check_equal("register readback", expected_reg(addr), rd);
    end
    axi_write(`REG_CTRL, 32'h0, 4'hF);
    axi_write(`REG_THRESH, 32'h0, 4'hF);
    axi_write(`REG_PAD, 32'h0, 4'hF);
  endtask

  //////////////////////////////////////////////////////////////
  // capture phases
  //////////////////////////////////////////////////////////////

  task automatic wait_drain();
    int quiet;
    quiet = 0;
    while (quiet < 24) begin
      @(posedge clk);
      if (m_axis_tvalid) quiet = 0;
      else quiet++;
    end
  endtask

  task automatic run_phase(input logic [1:0] en, input bit byp, input int cycles,
                           input bit skip, input int rmode);
    logic [31:0] da0;
    logic [31:0] db0;
    logic [31:0] da1;
    logic [31:0] db1;
    pushed    = '{0, 0};
    delivered = '{0, 0};
    skip_ok   = skip;
    axi_read(`REG_DROP_A, da0);
    axi_read(`REG_DROP_B, db0);
    ready_mode <= rmode;
    axi_write(`REG_CTRL, {29'b0, byp, en}, 4'h1);
    check_equal("a_enable pin", {31'b0, en[0]}, {31'b0, a_enable});
    check_equal("b_enable pin", {31'b0, en[1]}, {31'b0, b_enable});
    repeat (cycles) @(posedge clk);
    axi_write(`REG_CTRL, {29'b0, byp, 2'b00}, 4'h1);
    ready_mode <= 0;
    wait_drain();
    check_equal("a_enable pin off", 32'b0, {31'b0, a_enable});
    check_equal("b_enable pin off", 32'b0, {31'b0, b_enable});
    axi_read(`REG_DROP_A, da1);
    axi_read(`REG_DROP_B, db1);
    if (!skip) begin
      check_equal("rx_a drops", 32'b0, da1 - da0);
      check_equal("rx_b drops", 32'b0, db1 - db0);
      check_equal("rx_a words left", 32'b0, exp_a_q.size());
      check_equal("rx_b words left", 32'b0, exp_b_q.size());
    end
    check_equal("rx_a delivered plus dropped", pushed[0], delivered[0] + (da1 - da0));
    check_equal("rx_b delivered plus dropped", pushed[1], delivered[1] + (db1 - db0));
    exp_a_q.delete();
    exp_b_q.delete();
  endtask

  initial begin
    void'($urandom(64));
    clk = 1'b0;
    arst_n = 1'b0;
    {a_rx_frame_in, a_rx_data_p0, a_rx_data_p1} = '0;
    {b_rx_frame_in, b_rx_data_p0, b_rx_data_p1} = '0;
    {awaddr, awvalid, wdata, wstrb, wvalid} = '0;
    {araddr, arvalid} = '0;
    bready = 1'b1;
    rready = 1'b1;
    m_axis_tready = 1'b1;
    {en_a_m, en_b_m, byp_m, thr_m, pad_m} = '0;
    pad_left_m = '{0, 0, 0, 0};
    pushed = '{0, 0};
    delivered = '{0, 0};
    skip_ok = 1'b0;
    ready_mode = 0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    test_registers();
    run_phase(2'b00, 1'b0, IDLE_CYC, 1'b0, 0);
    run_phase(2'b01, 1'b0, A_CYC, 1'b0, 0);
    run_phase(2'b01, 1'b1, BYP_CYC, 1'b0, 0);
    run_phase(2'b10, 1'b1, BYP_CYC, 1'b0, 0);

    repeat (GATE_ROUNDS) begin
      axi_write(`REG_THRESH, $urandom_range(1200, 3200), 4'hF);
      axi_write(`REG_PAD, $urandom_range(0, 15), 4'hF);
      run_phase(2'b11, 1'b0, GATE_CYC, 1'b1, 0);
    end

    // back-pressure with the stream stalled and then with random tready
    run_phase(2'b11, 1'b1, HOLD_CYC, 1'b1, 1);
    run_phase(2'b11, 1'b1, RAND_CYC, 1'b1, 2);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dual_rx_top.sv
// dual receiver capture top: two receive paths, arbiter and registers

`timescale 1ns/1ps
`default_nettype none

`include "radio_rx_settings.svh"

module dual_rx_top (
  input  logic                     clk,
  input  logic                     arst_n,
  // receiver a pins
  input  logic                     a_rx_frame_in,
  input  logic [`RX_SAMPLE_W-1:0]  a_rx_data_p0,
  input  logic [`RX_SAMPLE_W-1:0]  a_rx_data_p1,
  // receiver b pins
  input  logic                     b_rx_frame_in,
  input  logic [`RX_SAMPLE_W-1:0]  b_rx_data_p0,
  input  logic [`RX_SAMPLE_W-1:0]  b_rx_data_p1,
  output logic                     a_enable,
  output logic                     b_enable,
  // axi4-lite slave
  input  logic [`RX_ADDR_W-1:0]    awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [`RX_ADDR_W-1:0]    araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  // sample stream out
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready,
  output logic [31:0]              m_axis_tdata
);

  logic                      bypass;
  logic [`RX_MAG_W-1:0]      threshold;
  logic [`RX_PAD_W-1:0]      pad_count;
  logic [`RX_DROP_W-1:0]     drop_a;
  logic [`RX_DROP_W-1:0]     drop_b;
  logic                      dfr_a_valid;
  logic                      dfr_b_valid;
  logic                      gate_a_valid;
  logic                      gate_b_valid;
  radio_rx_pkg::iq_sample_t  dfr_a_sample;
  radio_rx_pkg::iq_sample_t  dfr_b_sample;
  radio_rx_pkg::iq_sample_t  gate_a_sample;
  radio_rx_pkg::iq_sample_t  gate_b_sample;

  rx_sample_if fifo_a_if ();
  rx_sample_if fifo_b_if ();

  ////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////

  rx_ctrl_regs u_regs (
    .*,
    .enable_a (a_enable),
    .enable_b (b_enable)
  );

  ////////////////////////////////////////////////////////////
  // receive path a
  ////////////////////////////////////////////////////////////

  cmos_rx_deframer #(.RX_INDEX(0)) u_dfr_a (
    .clk (clk), .arst_n (arst_n), .enable (a_enable),
    .rx_frame_in (a_rx_frame_in),
    .rx_data_p0 (a_rx_data_p0), .rx_data_p1 (a_rx_data_p1),
    .sample_valid (dfr_a_valid), .sample (dfr_a_sample)
  );

  sample_gate u_gate_a (
    .clk (clk), .arst_n (arst_n),
    .in_valid (dfr_a_valid), .in_sample (dfr_a_sample),
    .threshold (threshold), .pad_count (pad_count), .bypass (bypass),
    .out_valid (gate_a_valid), .out_sample (gate_a_sample)
  );

  sample_fifo u_fifo_a (
    .clk (clk), .arst_n (arst_n),
    .in_valid (gate_a_valid), .in_sample (gate_a_sample),
    .out (fifo_a_if.source), .drop_count (drop_a)
  );

  ////////////////////////////////////////////////////////////
  // receive path b
  ////////////////////////////////////////////////////////////

  cmos_rx_deframer #(.RX_INDEX(1)) u_dfr_b (
    .clk (clk), .arst_n (arst_n), .enable (b_enable),
    .rx_frame_in (b_rx_frame_in),
    .rx_data_p0 (b_rx_data_p0), .rx_data_p1 (b_rx_data_p1),
    .sample_valid (dfr_b_valid), .sample (dfr_b_sample)
  );

  sample_gate u_gate_b (
    .clk (clk), .arst_n (arst_n),
    .in_valid (dfr_b_valid), .in_sample (dfr_b_sample),
    .threshold (threshold), .pad_count (pad_count), .bypass (bypass),
    .out_valid (gate_b_valid), .out_sample (gate_b_sample)
  );

  sample_fifo u_fifo_b (
    .clk (clk), .arst_n (arst_n),
    .in_valid (gate_b_valid), .in_sample (gate_b_sample),
    .out (fifo_b_if.source), .drop_count (drop_b)
  );

  // merge both FIFOs onto the output stream
  stream_arbiter u_arb (
    .clk (clk), .arst_n (arst_n),
    .src_a (fifo_a_if.sink), .src_b (fifo_b_if.sink),
    .m_axis_tvalid (m_axis_tvalid), .m_axis_tready (m_axis_tready),
    .m_axis_tdata (m_axis_tdata)
  );

endmodule

`default_nettype wire

//--- rx_ctrl_regs.sv
// axi4-lite register block for enables, gate settings and drop counts

`timescale 1ns/1ps
`default_nettype none

`include "radio_rx_settings.svh"

module rx_ctrl_regs (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [`RX_ADDR_W-1:0]   awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`RX_ADDR_W-1:0]   araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  input  logic [`RX_DROP_W-1:0]   drop_a,
  input  logic [`RX_DROP_W-1:0]   drop_b,
  output logic                    enable_a,
  output logic                    enable_b,
  output logic                    bypass,
  output logic [`RX_MAG_W-1:0]    threshold,
  output logic [`RX_PAD_W-1:0]    pad_count
);

  radio_rx_pkg::axil_state_e state;
  radio_rx_pkg::reg_addr_e   wr_addr;
  radio_rx_pkg::reg_addr_e   rd_addr;
  logic                      wr_accept;
  logic                      rd_accept;
  logic [31:0]               rd_mux;

  // write wins when both arrive together
  assign wr_accept = (state == radio_rx_pkg::axil_idle) & awvalid & wvalid;
  assign rd_accept = (state == radio_rx_pkg::axil_idle) & arvalid & ~wr_accept;

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;
  assign bvalid  = (state == radio_rx_pkg::axil_wresp);
  assign rvalid  = (state == radio_rx_pkg::axil_rdata);
  assign bresp   = 2'b00;
  assign rresp   = 2'b00;

  assign wr_addr = radio_rx_pkg::reg_addr_e'({awaddr[`RX_ADDR_W-1:2], 2'b00});
  assign rd_addr = radio_rx_pkg::reg_addr_e'({araddr[`RX_ADDR_W-1:2], 2'b00});

  ////////////////////////////////////////////////////////////
  // bus FSM and register writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= radio_rx_pkg::axil_idle;
      enable_a  <= 1'b0;
      enable_b  <= 1'b0;
      bypass    <= 1'b0;
      threshold <= '0;
      pad_count <= '0;
    end else begin
      case (state)
        radio_rx_pkg::axil_idle: begin
          if (wr_accept) state <= radio_rx_pkg::axil_wresp;
          else if (rd_accept) state <= radio_rx_pkg::axil_rdata;
        end
        radio_rx_pkg::axil_wresp: if (bready) state <= radio_rx_pkg::axil_idle;
        radio_rx_pkg::axil_rdata: if (rready) state <= radio_rx_pkg::axil_idle;
        default: state <= radio_rx_pkg::axil_idle;
      endcase
      if (wr_accept) begin
        case (wr_addr)
          radio_rx_pkg::reg_ctrl: begin
            if (wstrb[0]) {bypass, enable_b, enable_a} <= wdata[2:0];
          end
          radio_rx_pkg::reg_thresh: begin
            if (wstrb[0]) threshold[7:0] <= wdata[7:0];
            if (wstrb[1]) threshold[`RX_MAG_W-1:8] <= wdata[`RX_MAG_W-1:8];
          end
          radio_rx_pkg::reg_pad: if (wstrb[0]) pad_count <= wdata[`RX_PAD_W-1:0];
          // drop counters and unmapped offsets ignore writes
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (rd_addr)
      radio_rx_pkg::reg_ctrl:   rd_mux = {29'b0, bypass, enable_b, enable_a};
      radio_rx_pkg::reg_thresh: rd_mux = {{(32-`RX_MAG_W){1'b0}}, threshold};
      radio_rx_pkg::reg_pad:    rd_mux = {{(32-`RX_PAD_W){1'b0}}, pad_count};
      radio_rx_pkg::reg_drop_a: rd_mux = {{(32-`RX_DROP_W){1'b0}}, drop_a};
      radio_rx_pkg::reg_drop_b: rd_mux = {{(32-`RX_DROP_W){1'b0}}, drop_b};
      default:                  rd_mux = 32'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_accept) rdata <= rd_mux;
  end

endmodule

`default_nettype wire

//--- stream_arbiter.sv
// round-robin merge of two sample links into one output stream

`timescale 1ns/1ps
`default_nettype none

module stream_arbiter (
  input  logic         clk,
  input  logic         arst_n,
  rx_sample_if.sink    src_a,
  rx_sample_if.sink    src_b,
  output logic         m_axis_tvalid,
  input  logic         m_axis_tready,
  output logic [31:0]  m_axis_tdata
);

  logic load;
  logic prio_b;
  logic grant_a;
  logic grant_b;

  // output slot is free when empty or draining this cycle
  assign load = ~m_axis_tvalid | m_axis_tready;

  assign grant_a = load & src_a.valid & (~src_b.valid | ~prio_b);
  assign grant_b = load & src_b.valid & (~src_a.valid | prio_b);

  assign src_a.ready = grant_a;
  assign src_b.ready = grant_b;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_axis_tvalid <= 1'b0;
      prio_b        <= 1'b0;
    end else begin
      if (load) m_axis_tvalid <= grant_a | grant_b;
      // whoever just won goes to the back
      if (grant_a) prio_b <= 1'b1;
      if (grant_b) prio_b <= 1'b0;
    end
  end

  // word: tag 25:24, i 23:12, q 11:0
  always_ff @(posedge clk) begin
    if (grant_a) begin
      m_axis_tdata <= {6'b0, src_a.chan, src_a.i, src_a.q};
    end else if (grant_b) begin
      m_axis_tdata <= {6'b0, src_b.chan, src_b.i, src_b.q};
    end
  end

endmodule

`default_nettype wire

//--- sample_fifo.sv
// eight-entry dropping FIFO with saturating drop counter

`timescale 1ns/1ps
`default_nettype none

`include "radio_rx_settings.svh"

module sample_fifo (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        in_valid,
  input  radio_rx_pkg::iq_sample_t    in_sample,
  rx_sample_if.source                 out,
  output logic [`RX_DROP_W-1:0]       drop_count
);

  localparam int PTR_W = $clog2(`RX_FIFO_DEPTH);

  radio_rx_pkg::iq_sample_t mem [`RX_FIFO_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W:0]           count;
  logic                     full;
  logic                     push;
  logic                     pop;

  assign full = (count == (PTR_W+1)'(`RX_FIFO_DEPTH));
  assign push = in_valid & ~full;
  assign pop  = out.valid & out.ready;

  assign out.valid = (count != '0);
  assign out.i     = mem[rd_ptr].i;
  assign out.q     = mem[rd_ptr].q;
  assign out.chan  = mem[rd_ptr].chan;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      drop_count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + push - pop;
      // a full FIFO loses the sample since the radio cannot stall
      if (in_valid && full && drop_count != '1) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_sample;
  end

endmodule

`default_nettype wire

//--- sample_gate.sv
// magnitude threshold gate with per-channel trailing padding

`timescale 1ns/1ps
`default_nettype none

`include "radio_rx_settings.svh"

module sample_gate (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        in_valid,
  input  radio_rx_pkg::iq_sample_t    in_sample,
  input  logic [`RX_MAG_W-1:0]        threshold,
  input  logic [`RX_PAD_W-1:0]        pad_count,
  input  logic                        bypass,
  output logic                        out_valid,
  output radio_rx_pkg::iq_sample_t    out_sample
);

  logic [`RX_SAMPLE_W-1:0] abs_i;
  logic [`RX_SAMPLE_W-1:0] abs_q;
  logic [`RX_MAG_W-1:0]    mag;
  logic                    above;
  logic                    chan_sel;
  logic [`RX_PAD_W-1:0]    pad_left [2];
  logic                    pass;

  ////////////////////////////////////////////////////////////
  // magnitude and decision
  ////////////////////////////////////////////////////////////

  // -2048 wraps to 12'h800, still right as unsigned
  assign abs_i = in_sample.i[`RX_SAMPLE_W-1] ? -in_sample.i : in_sample.i;
  assign abs_q = in_sample.q[`RX_SAMPLE_W-1] ? -in_sample.q : in_sample.q;
  assign mag   = {1'b0, abs_i} + {1'b0, abs_q};
  assign above = (mag >= threshold);

  assign chan_sel = in_sample.chan[0];
  assign pass     = bypass | above | (pad_left[chan_sel] != '0);

  // trailing pad countdown, one per channel
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pad_left[0] <= '0;
      pad_left[1] <= '0;
    end else if (in_valid) begin
      if (above) begin
        pad_left[chan_sel] <= pad_count;
      end else if (pad_left[chan_sel] != '0) begin
        pad_left[chan_sel] <= pad_left[chan_sel] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid & pass;
    end
  end

  always_ff @(posedge clk) begin
    out_sample <= in_sample;
  end

endmodule

`default_nettype wire

//--- cmos_rx_deframer.sv
// single data rate deframer for one cmos receive port

`timescale 1ns/1ps
`default_nettype none

`include "radio_rx_settings.svh"

module cmos_rx_deframer #(
  parameter int RX_INDEX = 0
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        enable,
  input  logic                        rx_frame_in,
  input  logic [`RX_SAMPLE_W-1:0]     rx_data_p0,
  input  logic [`RX_SAMPLE_W-1:0]     rx_data_p1,
  output logic                        sample_valid,
  output radio_rx_pkg::iq_sample_t    sample
);

  logic [1:0] tag;

  // receiver index on bit 1, frame low means channel 1
  assign tag = {RX_INDEX[0], ~rx_frame_in};

  ////////////////////////////////////////////////////////////
  // pin capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sample_valid <= 1'b0;
    end else begin
      // radio is idle while disabled, nothing goes downstream
      sample_valid <= enable;
    end
  end

  always_ff @(posedge clk) begin
    sample.i    <= rx_data_p0;
    sample.q    <= rx_data_p1;
    sample.chan <= radio_rx_pkg::chan_id_e'(tag);
  end

endmodule

`default_nettype wire

//--- rx_sample_if.sv
// valid/ready sample link with source and sink views

`timescale 1ns/1ps
`default_nettype none

`include "radio_rx_settings.svh"

interface rx_sample_if;

  logic                            valid;
  logic                            ready;
  logic signed [`RX_SAMPLE_W-1:0]  i;
  logic signed [`RX_SAMPLE_W-1:0]  q;
  radio_rx_pkg::chan_id_e          chan;

  // source holds valid and data until ready is seen
  modport source (
    output valid, i, q, chan,
    input  ready
  );

  modport sink (
    input  valid, i, q, chan,
    output ready
  );

endinterface

`default_nettype wire

//--- radio_rx_pkg.sv
// sample struct, channel tags, register map and bus state types

`default_nettype none

`include "radio_rx_settings.svh"

package radio_rx_pkg;

  // stream tag, bit 1 picks the receiver, bit 0 the channel
  typedef enum logic [1:0] {
    rx_a_ch0 = 2'd0,
    rx_a_ch1 = 2'd1,
    rx_b_ch0 = 2'd2,
    rx_b_ch1 = 2'd3
  } chan_id_e;

  // chan on top so the word lines up with the stream layout
  typedef struct packed {
    chan_id_e                        chan;
    logic signed [`RX_SAMPLE_W-1:0]  i;
    logic signed [`RX_SAMPLE_W-1:0]  q;
  } iq_sample_t;

  typedef enum logic [`RX_ADDR_W-1:0] {
    reg_ctrl   = `REG_CTRL,
    reg_thresh = `REG_THRESH,
    reg_pad    = `REG_PAD,
    reg_drop_a = `REG_DROP_A,
    reg_drop_b = `REG_DROP_B
  } reg_addr_e;

  typedef enum logic [1:0] {
    axil_idle,
    axil_wresp,
    axil_rdata
  } axil_state_e;

endpackage

`default_nettype wire

//--- radio_rx_settings.svh
// widths, depths and register offsets for the dual receive capture path

`ifndef RADIO_RX_SETTINGS_SVH
`define RADIO_RX_SETTINGS_SVH

// sample and gate widths
`define RX_SAMPLE_W   12
`define RX_MAG_W      13
`define RX_PAD_W      4

// fifo and drop counters
`define RX_FIFO_DEPTH 8
`define RX_DROP_W     16

// axi4-lite register map, byte offsets
`define RX_ADDR_W     8
`define REG_CTRL      8'h00
`define REG_THRESH    8'h04
`define REG_PAD       8'h08
`define REG_DROP_A    8'h0C
`define REG_DROP_B    8'h10

`endif
